/* logic/uart.sv */
// UART top level; reset divisor is CLOCK_FREQ_HZ / BAUD_RATE - 1, no parity or flow control
module uart #(
  parameter int unsigned CLOCK_FREQ_HZ = 10000000,
  parameter int unsigned BAUD_RATE     = 115200
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd_en,
  input  logic                 wr_en,
  input  uart_pkg::reg_addr_t  addr,
  input  uart_pkg::word_t      wr_data,
  output uart_pkg::word_t      rd_data,
  output logic                 busy,
  output logic                 txd,
  input  logic                 rxd,
  output logic                 irq
);

  uart_fifo_if tx_q ();
  uart_fifo_if rx_q ();

  logic               tx_en;
  logic               nstop;
  logic               rx_en;
  uart_pkg::divisor_t divisor;

  uart_fifo tx_fifo (.clock(clock), .reset(reset), .q(tx_q));
  uart_fifo rx_fifo (.clock(clock), .reset(reset), .q(rx_q));

  uart_tx tx (
    .clock(clock), .reset(reset),
    .tx_en(tx_en), .nstop(nstop), .divisor(divisor),
    .q(tx_q), .txd(txd)
  );

  uart_rx rx (
    .clock(clock), .reset(reset),
    .rx_en(rx_en), .divisor(divisor),
    .rxd(rxd), .q(rx_q)
  );

  uart_regs #(
    .CLOCK_FREQ_HZ(CLOCK_FREQ_HZ),
    .BAUD_RATE(BAUD_RATE)
  ) regs (
    .clock(clock), .reset(reset),
    .rd_en(rd_en), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
    .rd_data(rd_data), .busy(busy), .irq(irq),
    .tx_en(tx_en), .nstop(nstop), .rx_en(rx_en), .divisor(divisor),
    .tx_q(tx_q), .rx_q(rx_q)
  );

endmodule

/* logic/uart_fifo.sv */
// Eight-entry byte queue; head data is undefined while empty, storage has no reset
module uart_fifo (
  input  logic       clock,
  input  logic       reset,
  uart_fifo_if.fifo  q
);

  uart_pkg::byte_t  mem [8];
  logic [2:0]       wr_ptr;
  logic [2:0]       rd_ptr;
  uart_pkg::level_t count;
  logic             do_push;
  logic             do_pop;

  assign do_push = q.push && !q.full;
  assign do_pop  = q.pop && !q.empty;

  assign q.pop_data = mem[rd_ptr];
  assign q.level    = count;
  assign q.empty    = (count == 4'd0);
  assign q.full     = (count == uart_pkg::FIFO_DEPTH);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 3'd1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 3'd1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  level_in_range: assert property (
    @(posedge clock) disable iff (reset) count <= uart_pkg::FIFO_DEPTH
  );

  // Every entry that can be popped was written first
  head_known: assert property (
    @(posedge clock) disable iff (reset) !q.empty |-> !$isunknown(q.pop_data)
  );

endmodule

/* logic/uart_fifo_if.sv */
// Byte queue handshake; push when full and pop when empty are ignored, flags lag by one cycle
interface uart_fifo_if;

  logic               push;
  uart_pkg::byte_t    push_data;
  logic               pop;
  uart_pkg::byte_t    pop_data;
  logic               empty;
  logic               full;
  uart_pkg::level_t   level;

  // Producer side
  modport writer (output push, push_data, input empty, full, level);

  // Consumer side, pop_data is the head entry
  modport reader (output pop, input pop_data, empty, full, level);

  // Storage side
  modport fifo (input push, push_data, pop, output pop_data, empty, full, level);

endinterface

/* logic/uart_pkg.sv */
// Shared UART types and register map; queue depth is fixed at 8 by the 3-bit watermark fields
package uart_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] divisor_t;
  typedef logic [3:0]  level_t;

  // Queue depth, tied to level_t and the watermark field width
  localparam level_t FIFO_DEPTH = 4'd8;

  // Register byte offsets, bits 4..2 select the register
  localparam reg_addr_t TXDATA_ADDR = 5'h00;
  localparam reg_addr_t RXDATA_ADDR = 5'h04;
  localparam reg_addr_t TXCTRL_ADDR = 5'h08;
  localparam reg_addr_t RXCTRL_ADDR = 5'h0C;
  localparam reg_addr_t IE_ADDR     = 5'h10;
  localparam reg_addr_t IP_ADDR     = 5'h14;
  localparam reg_addr_t DIV_ADDR    = 5'h18;

  // Field positions inside the data word
  localparam int CTRL_EN_BIT    = 0;
  localparam int CTRL_NSTOP_BIT = 1;
  localparam int CTRL_CNT_LSB   = 16;
  localparam int FLAG_BIT       = 31;
  localparam int TXWM_BIT       = 0;
  localparam int RXWM_BIT       = 1;

  typedef enum logic [1:0] {BUS_IDLE, BUS_READ, BUS_WRITE, BUS_SETTLE} bus_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

/* logic/uart_regs.sv */
// Register block on a three-cycle request/busy bus; requests while busy are ignored
module uart_regs #(
  parameter int unsigned CLOCK_FREQ_HZ = 10000000,
  parameter int unsigned BAUD_RATE     = 115200
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd_en,
  input  logic                 wr_en,
  input  uart_pkg::reg_addr_t  addr,
  input  uart_pkg::word_t      wr_data,
  output uart_pkg::word_t      rd_data,
  output logic                 busy,
  output logic                 irq,
  output logic                 tx_en,
  output logic                 nstop,
  output logic                 rx_en,
  output uart_pkg::divisor_t   divisor,
  uart_fifo_if.writer          tx_q,
  uart_fifo_if.reader          rx_q
);

  localparam uart_pkg::divisor_t DIV_RESET =
    uart_pkg::divisor_t'(CLOCK_FREQ_HZ / BAUD_RATE - 1);

  uart_pkg::bus_state_t state;
  uart_pkg::reg_addr_t  req_addr;
  uart_pkg::word_t      req_data;
  uart_pkg::word_t      read_word;
  uart_pkg::level_t     txcnt;
  uart_pkg::level_t     rxcnt;
  logic [1:0]           ie;
  logic [1:0]           ip;
  logic                 do_write;
  logic                 do_read;

  assign busy     = (state != uart_pkg::BUS_IDLE);
  assign do_write = (state == uart_pkg::BUS_WRITE);
  assign do_read  = (state == uart_pkg::BUS_READ);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= uart_pkg::BUS_IDLE;
    end else begin
      case (state)
        uart_pkg::BUS_IDLE: begin
          if (rd_en) begin
            state <= uart_pkg::BUS_READ;
          end else if (wr_en) begin
            state <= uart_pkg::BUS_WRITE;
          end
        end
        uart_pkg::BUS_READ, uart_pkg::BUS_WRITE: state <= uart_pkg::BUS_SETTLE;
        default: state <= uart_pkg::BUS_IDLE;
      endcase
    end
  end

  // Request captured at acceptance; rd_data held until the next read
  always_ff @(posedge clock) begin
    if (state == uart_pkg::BUS_IDLE) begin
      req_addr <= addr;
      req_data <= wr_data;
    end
    if (do_read) begin
      rd_data <= read_word;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_en   <= 1'b0;
      nstop   <= 1'b0;
      rx_en   <= 1'b0;
      txcnt   <= '0;
      rxcnt   <= '0;
      ie      <= '0;
      divisor <= DIV_RESET;
    end else if (do_write) begin
      case (req_addr[4:2])
        uart_pkg::TXCTRL_ADDR[4:2]: begin
          tx_en <= req_data[uart_pkg::CTRL_EN_BIT];
          nstop <= req_data[uart_pkg::CTRL_NSTOP_BIT];
          txcnt <= {1'b0, req_data[uart_pkg::CTRL_CNT_LSB +: 3]};
        end
        uart_pkg::RXCTRL_ADDR[4:2]: begin
          rx_en <= req_data[uart_pkg::CTRL_EN_BIT];
          rxcnt <= {1'b0, req_data[uart_pkg::CTRL_CNT_LSB +: 3]};
        end
        uart_pkg::IE_ADDR[4:2]: begin
          ie <= {req_data[uart_pkg::RXWM_BIT], req_data[uart_pkg::TXWM_BIT]};
        end
        uart_pkg::DIV_ADDR[4:2]: begin
          divisor <= req_data[15:0];
        end
        default: ;
      endcase
    end
  end

  // Queue side effects of an access
  assign tx_q.push      = do_write && (req_addr[4:2] == uart_pkg::TXDATA_ADDR[4:2]);
  assign tx_q.push_data = req_data[7:0];
  assign rx_q.pop       = do_read && (req_addr[4:2] == uart_pkg::RXDATA_ADDR[4:2]) &&
                          !rx_q.empty;

  // Raw watermark conditions
  assign ip[uart_pkg::TXWM_BIT] = (tx_q.level < txcnt);
  assign ip[uart_pkg::RXWM_BIT] = (rx_q.level > rxcnt);

  always_comb begin
    read_word = '0;
    case (req_addr[4:2])
      uart_pkg::TXDATA_ADDR[4:2]: read_word[uart_pkg::FLAG_BIT] = tx_q.full;
      uart_pkg::RXDATA_ADDR[4:2]: begin
        read_word[uart_pkg::FLAG_BIT] = rx_q.empty;
        // Head is stale while empty
        read_word[7:0] = rx_q.empty ? 8'h00 : rx_q.pop_data;
      end
      uart_pkg::TXCTRL_ADDR[4:2]: begin
        read_word[uart_pkg::CTRL_EN_BIT]       = tx_en;
        read_word[uart_pkg::CTRL_NSTOP_BIT]    = nstop;
        read_word[uart_pkg::CTRL_CNT_LSB +: 3] = txcnt[2:0];
      end
      uart_pkg::RXCTRL_ADDR[4:2]: begin
        read_word[uart_pkg::CTRL_EN_BIT]       = rx_en;
        read_word[uart_pkg::CTRL_CNT_LSB +: 3] = rxcnt[2:0];
      end
      uart_pkg::IE_ADDR[4:2]:  read_word[1:0] = ie;
      uart_pkg::IP_ADDR[4:2]:  read_word[1:0] = ip;
      uart_pkg::DIV_ADDR[4:2]: read_word[15:0] = divisor;
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq <= 1'b0;
    end else begin
      irq <= |(ip & ie);
    end
  end

  // A txdata push only in the cycle after an accepted write request
  push_after_write_request: assert property (
    @(posedge clock) disable iff (reset)
      tx_q.push |-> $past(wr_en && !rd_en && !busy)
  );

  // An rxdata pop only in the cycle after an accepted read request
  pop_after_read_request: assert property (
    @(posedge clock) disable iff (reset)
      rx_q.pop |-> $past(rd_en && !busy)
  );

endmodule

/* logic/uart_rx.sv */
// Serial receiver, 8 data bits, no parity; frames with a low stop bit are dropped
module uart_rx (
  input  logic                clock,
  input  logic                reset,
  input  logic                rx_en,
  input  uart_pkg::divisor_t  divisor,
  input  logic                rxd,
  uart_fifo_if.writer         q
);

  uart_pkg::rx_state_t state;
  uart_pkg::divisor_t  cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift;
  logic                rxd_meta;
  logic                rxd_sync;
  logic                rxd_prev;
  logic                fall;
  logic                bit_done;
  logic                half_done;

  // Two-flop synchronizer plus one more stage for edge detection
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall      = rxd_prev && !rxd_sync;
  assign bit_done  = (cnt == divisor);
  assign half_done = (cnt == (divisor >> 1));

  // Push at the first stop sample only if the line is high there
  assign q.push      = (state == uart_pkg::RX_STOP) && bit_done && rxd_sync && !q.full;
  assign q.push_data = shift;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= uart_pkg::RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        uart_pkg::RX_IDLE: begin
          cnt <= '0;
          if (rx_en && fall) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (half_done) begin
            cnt     <= '0;
            bit_idx <= '0;
            // A start bit gone high again was a glitch
            state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_done) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 3'd1;
            end
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
        default: begin
          if (bit_done) begin
            cnt   <= '0;
            state <= uart_pkg::RX_IDLE;
          end else begin
            cnt <= cnt + 16'd1;
          end
        end
      endcase
    end
  end

  // Assembled LSB first
  always_ff @(posedge clock) begin
    if (state == uart_pkg::RX_DATA && bit_done) begin
      shift <= {rxd_sync, shift[7:1]};
    end
  end

endmodule

/* logic/uart_tx.sv */
// Serial transmitter, 8N1 or 8N2, no parity; bit period is divisor plus one clocks
module uart_tx (
  input  logic                clock,
  input  logic                reset,
  input  logic                tx_en,
  input  logic                nstop,
  input  uart_pkg::divisor_t  divisor,
  uart_fifo_if.reader         q,
  output logic                txd
);

  uart_pkg::tx_state_t state;
  uart_pkg::divisor_t  cnt;
  logic [2:0]          bit_idx;
  logic                second_stop;
  uart_pkg::byte_t     shift;
  logic                bit_done;
  logic                last_stop;
  logic                load;

  assign bit_done  = (cnt == divisor);
  assign last_stop = !nstop || second_stop;

  // Fetch a byte when idle, or back to back at the end of the last stop bit
  assign load = tx_en && !q.empty &&
                (state == uart_pkg::TX_IDLE ||
                 (state == uart_pkg::TX_STOP && bit_done && last_stop));

  assign q.pop = load;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= uart_pkg::TX_IDLE;
      cnt         <= '0;
      bit_idx     <= '0;
      second_stop <= 1'b0;
      txd         <= 1'b1;
    end else if (load) begin
      state       <= uart_pkg::TX_START;
      cnt         <= '0;
      second_stop <= 1'b0;
      txd         <= 1'b0;
    end else begin
      if (state != uart_pkg::TX_IDLE) begin
        cnt <= bit_done ? '0 : cnt + 16'd1;
      end
      case (state)
        uart_pkg::TX_START: begin
          if (bit_done) begin
            state   <= uart_pkg::TX_DATA;
            bit_idx <= '0;
            txd     <= shift[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::TX_STOP;
              txd   <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              txd     <= shift[1];
            end
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_done) begin
            if (last_stop) begin
              state <= uart_pkg::TX_IDLE;
            end else begin
              second_stop <= 1'b1;
            end
          end
        end
        default: begin
          txd <= 1'b1;
        end
      endcase
    end
  end

  // LSB goes out first
  always_ff @(posedge clock) begin
    if (load) begin
      shift <= q.pop_data;
    end else if (state == uart_pkg::TX_DATA && bit_done) begin
      shift <= shift >> 1;
    end
  end

  line_idles_high: assert property (
    @(posedge clock) disable iff (reset) state == uart_pkg::TX_IDLE |-> txd
  );

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module uart_tb -o uart_sim &&
  ./obj_dir/uart_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
  echo "Simulation run passed" || { echo "Simulation run failed"; exit 1; }

/* tb.f */
logic/uart_pkg.sv
logic/uart_fifo_if.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart.sv
test/uart_tb.sv

/* test/uart_input.txt */
# Columns: op addr data expect, in hex. W write, R read and compare, T send byte,
# B random burst of data bytes, P read back data bytes, D drain txd, S drive rxd, I check irq
R 00 0 00000000
R 04 0 80000000
R 08 0 00000000
R 0C 0 00000000
R 10 0 00000000
R 14 0 00000000
R 18 0 00000055
I 0 0 0
W 18 0000000F 0
R 18 0 0000000F
W 0C 00000001 0
W 08 00000001 0
T 0 41 0
T 0 7E 0
D 0 0 0
P 0 2 0
R 04 0 80000000
W 08 00000003 0
T 0 C3 0
B 0 3 0
D 0 0 0
P 0 4 0
W 08 00000000 0
B 0 8 0
W 00 000000FF 0
R 00 0 80000000
W 08 00040000 0
R 14 0 00000000
W 10 00000003 0
I 0 0 0
W 08 00040001 0
D 0 0 0
R 14 0 00000003
I 0 0 1
W 10 00000002 0
W 0C 00070001 0
I 0 0 1
P 0 1 0
I 0 0 0
R 14 0 00000001
P 0 7 0
W 08 00000001 0
S 0 5A 0
R 04 0 80000000
S 0 A5 1
P 0 1 0
I 0 0 0

/* test/uart_tb.sv */
// Testbench for uart; run from the project root, divisor and nstop change only while txd is idle
module uart_tb;

  localparam int CLOCK_FREQ_HZ = 10000000;
  localparam int BAUD_RATE     = 115200;
  localparam int BUS_TIMEOUT   = 20;
  localparam int POLL_LIMIT    = 1000;
  localparam int DRAIN_LIMIT   = 50000;

  logic                clock;
  logic                reset;
  logic                rd_en;
  logic                wr_en;
  uart_pkg::reg_addr_t addr;
  uart_pkg::word_t     wr_data;
  uart_pkg::word_t     rd_data;
  logic                busy;
  logic                txd;
  logic                rxd;
  logic                irq;
  logic                loopback;
  logic                rxd_drv;

  // Line settings as last written over the bus
  int                  div_cur;
  logic                nstop_cur;
  logic [31:0]         rand_state;
  uart_pkg::byte_t     tx_expect[$];
  uart_pkg::byte_t     rx_expect[$];
  logic                in_frame;
  int                  errors;
  int                  checks;

  uart #(.CLOCK_FREQ_HZ(CLOCK_FREQ_HZ), .BAUD_RATE(BAUD_RATE)) dut (
    .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .rd_data(rd_data), .busy(busy), .txd(txd), .rxd(rxd), .irq(irq)
  );

  assign rxd = loopback ? txd : rxd_drv;

  always #20 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic bus_access(input logic is_read, input uart_pkg::reg_addr_t a,
                            input uart_pkg::word_t d, output uart_pkg::word_t r);
    int cycles;
    addr    = a;
    wr_data = d;
    rd_en   = is_read;
    wr_en   = !is_read;
    next_cycle();
    rd_en  = 1'b0;
    wr_en  = 1'b0;
    cycles = 1;
    while (busy && cycles < BUS_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    r = rd_data;
    checks++;
    assert (cycles == 3) else begin
      errors++;
      if (busy) begin
        $display("Bus access to %h never finished, busy stuck at time %0t", a, $time);
      end else begin
        $display("Mismatch at time %0t: busy cycles got %0d expected 3", $time, cycles);
      end
    end
  endtask

  task automatic write_reg(input uart_pkg::reg_addr_t a, input uart_pkg::word_t d);
    uart_pkg::word_t ignored;
    bus_access(1'b0, a, d, ignored);
    if (a == uart_pkg::DIV_ADDR) begin
      div_cur = int'(d[15:0]);
    end
    if (a == uart_pkg::TXCTRL_ADDR) begin
      nstop_cur = d[uart_pkg::CTRL_NSTOP_BIT];
    end
  endtask

  task automatic check_read(input uart_pkg::reg_addr_t a, input uart_pkg::word_t e);
    uart_pkg::word_t got;
    bus_access(1'b1, a, '0, got);
    checks++;
    assert (got === e) else begin
      errors++;
      $display("Mismatch at time %0t: rd_data at %h got %h expected %h", $time, a, got, e);
    end
  endtask

  // Queued byte goes out on txd and, through the loop, into rxdata
  task automatic send_byte(input uart_pkg::byte_t b);
    write_reg(uart_pkg::TXDATA_ADDR, {24'h0, b});
    tx_expect.push_back(b);
    rx_expect.push_back(b);
  endtask

  task automatic read_back();
    int              polls;
    uart_pkg::word_t got;
    uart_pkg::byte_t want;
    polls = 0;
    got   = 32'h8000_0000;
    while (got[uart_pkg::FLAG_BIT] && polls < POLL_LIMIT) begin
      bus_access(1'b1, uart_pkg::RXDATA_ADDR, '0, got);
      polls++;
    end
    checks++;
    assert (!got[uart_pkg::FLAG_BIT]) else begin
      errors++;
      $display("No byte arrived in rxdata before the poll limit at time %0t", $time);
    end
    assert (rx_expect.size() > 0) else begin
      errors++;
      $display("Read back a byte with none expected at time %0t", $time);
    end
    if (rx_expect.size() > 0) begin
      want = rx_expect.pop_front();
      assert (got[uart_pkg::FLAG_BIT] || got[7:0] == want) else begin
        errors++;
        $display("Mismatch at time %0t: rxdata got %h expected %h", $time, got[7:0], want);
      end
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((tx_expect.size() != 0 || in_frame) && n < DRAIN_LIMIT) begin
      next_cycle();
      n++;
    end
    checks++;
    assert (tx_expect.size() == 0 && !in_frame) else begin
      errors++;
      $display("Frames still missing on txd at time %0t", $time);
    end
    // Let the last stop bit finish
    wait_cycles(div_cur + 1);
  endtask

  task automatic drive_frame(input uart_pkg::byte_t b, input logic stop);
    uart_pkg::byte_t bits;
    bits     = b;
    loopback = 1'b0;
    rxd_drv  = 1'b0;
    wait_cycles(div_cur + 1);
    repeat (8) begin
      rxd_drv = bits[0];
      bits    = bits >> 1;
      wait_cycles(div_cur + 1);
    end
    rxd_drv = stop;
    wait_cycles(div_cur + 1);
    rxd_drv = 1'b1;
    wait_cycles(2 * (div_cur + 1));
    loopback = 1'b1;
    if (stop) begin
      rx_expect.push_back(b);
    end
  endtask

  task automatic check_irq(input logic e);
    checks++;
    assert (irq === e) else begin
      errors++;
      $display("Mismatch at time %0t: irq got %b expected %b", $time, irq, e);
    end
  endtask

  // Samples at bit middles, starting from the falling edge of the start bit
  task automatic decode_frame(output uart_pkg::byte_t data, output logic framed);
    framed = 1'b1;
    data   = '0;
    wait_cycles((div_cur + 1) / 2);
    if (txd) begin
      framed = 1'b0;
    end
    repeat (8) begin
      wait_cycles(div_cur + 1);
      data = {txd, data[7:1]};
    end
    wait_cycles(div_cur + 1);
    if (!txd) begin
      framed = 1'b0;
    end
    if (nstop_cur) begin
      wait_cycles(div_cur + 1);
      if (!txd) begin
        framed = 1'b0;
      end
    end
  endtask

  initial begin : txd_monitor
    uart_pkg::byte_t got;
    uart_pkg::byte_t want;
    logic            framed;
    logic            prev;
    in_frame = 1'b0;
    prev     = 1'b1;
    forever begin
      next_cycle();
      if (!reset && prev && !txd) begin
        in_frame = 1'b1;
        decode_frame(got, framed);
        checks++;
        assert (framed) else begin
          errors++;
          $display("Bad start or stop bit on txd at time %0t", $time);
        end
        assert (tx_expect.size() > 0) else begin
          errors++;
          $display("Unexpected frame %h on txd at time %0t", got, $time);
        end
        if (tx_expect.size() > 0) begin
          want = tx_expect.pop_front();
          assert (got == want) else begin
            errors++;
            $display("Mismatch at time %0t: txd frame got %h expected %h", $time, got, want);
          end
        end
        in_frame = 1'b0;
      end
      prev = txd;
    end
  end

  task automatic run_command(input logic [7:0] op, input logic [31:0] a,
                             input logic [31:0] d, input logic [31:0] e);
    case (op)
      "W": write_reg(a[4:0], d);
      "R": check_read(a[4:0], e);
      "T": send_byte(d[7:0]);
      "B": begin
        repeat (d) begin
          rand_state = xorshift(rand_state);
          send_byte(rand_state[7:0]);
        end
      end
      "P": repeat (d) read_back();
      "D": drain();
      "S": drive_frame(d[7:0], e[0]);
      "I": check_irq(e[0]);
      default: begin
        errors++;
        $display("Unknown command %c in the input file", op);
      end
    endcase
  endtask

  initial begin
    int         fd;
    int         c;
    int         n;
    logic [7:0] ch;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    clock      = 1'b0;
    reset      = 1'b1;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    wr_data    = '0;
    loopback   = 1'b1;
    rxd_drv    = 1'b1;
    errors     = 0;
    checks     = 0;
    div_cur    = CLOCK_FREQ_HZ / BAUD_RATE - 1;
    nstop_cur  = 1'b0;
    rand_state = 32'had13;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    fd = $fopen("test/uart_input.txt", "r");
    checks++;
    assert (fd != 0) else begin
      errors++;
      $display("Could not open test/uart_input.txt");
    end
    if (fd != 0) begin
      c = $fgetc(fd);
      while (c != -1) begin
        ch = c[7:0];
        if (ch == "#") begin
          while (c != -1 && c[7:0] != "\n") begin
            c = $fgetc(fd);
          end
        end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
          n = $fscanf(fd, "%h %h %h", a, d, e);
          assert (n == 3) else begin
            errors++;
            $display("Malformed command %c in the input file", ch);
          end
          if (n == 3) begin
            run_command(ch, a, d, e);
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
